//--- pcie_os_pkg.sv
// ordered-set symbols, the 16-symbol set type
// and builders for TS1, TS2 and idle sets
package pcie_os_pkg;

  typedef logic [7:0] os_sym_t;

  // ------------------------------
  // symbols
  // ------------------------------
  localparam os_sym_t SYM_COM    = 8'hBC;
  localparam os_sym_t SYM_PAD    = 8'hF7;
  localparam os_sym_t SYM_TS1_ID = 8'h4A;
  localparam os_sym_t SYM_TS2_ID = 8'h45;

  localparam int OS_SYMBOLS = 16;

  // symbol 0 sits in the low byte, so it goes out first
  typedef os_sym_t [OS_SYMBOLS-1:0] ordered_set_t;

  // advertised rates, 2.5 GT/s only
  localparam os_sym_t RATE_ID_BASE = 8'h02;
  localparam int RATE_CHANGE_BIT = 6;

  // ------------------------------
  // builders
  // ------------------------------
  function automatic ordered_set_t build_ts(os_sym_t id, os_sym_t link, logic rate_change);
    ordered_set_t os;
    os = '0;
    os[0] = SYM_COM;
    os[1] = link;
    // lane number not assigned by this port
    os[2] = SYM_PAD;
    os[4] = RATE_ID_BASE;
    os[4][RATE_CHANGE_BIT] = rate_change;
    for (int i = 6; i < OS_SYMBOLS; i++) begin
      os[i] = id;
    end
    return os;
  endfunction

  function automatic ordered_set_t build_ts1(os_sym_t link, logic rate_change);
    return build_ts(SYM_TS1_ID, link, rate_change);
  endfunction

  function automatic ordered_set_t build_ts2(os_sym_t link);
    return build_ts(SYM_TS2_ID, link, 1'b0);
  endfunction

  // logical idle is all zero symbols
  function automatic ordered_set_t build_idle();
    return '0;
  endfunction

endpackage

//--- ltssm_cfg_pkg.sv
// configuration substate encoding and per-lane count thresholds
package ltssm_cfg_pkg;

  typedef enum logic [3:0] {
    CFG_IDLE,
    CFG_LW_START,
    CFG_LW_ACCEPT,
    CFG_LN_WAIT,
    CFG_LN_ACCEPT,
    CFG_COMPLETE,
    CFG_IDLE_OS,
    CFG_WAIT_EN_LOW
  } cfg_state_e;

  // consecutive sets needed per lane
  localparam int TS1_NEEDED  = 2;
  localparam int TS2_NEEDED  = 8;
  localparam int IDLE_NEEDED = 8;

  // idle frames to send after the first idle is seen
  localparam int IDLE_SENT_NEEDED = 16;

endpackage

//--- os_lane_counter.sv
// per-lane counter of consecutive qualifying TS1, TS2 and idle sets
`timescale 1ns/100ps

module os_lane_counter
  import pcie_os_pkg::*;
  import ltssm_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  cfg_state_e state_i,
  input  logic       ts1_valid_i,
  input  logic       ts2_valid_i,
  input  logic       idle_valid_i,
  input  os_sym_t    link_num_i,
  input  os_sym_t    lane_num_i,
  input  os_sym_t    lane_tx_i,
  input  os_sym_t    link_sel_i,
  output logic       done_o,
  output logic       idle_seen_o
);

  localparam int MAX_TS = (TS1_NEEDED > TS2_NEEDED) ? TS1_NEEDED : TS2_NEEDED;
  localparam int MAX_NEEDED = (MAX_TS > IDLE_NEEDED) ? MAX_TS : IDLE_NEEDED;
  localparam int CNT_W = $clog2(MAX_NEEDED + 1);

  cfg_state_e       state_r;
  logic [CNT_W-1:0] cnt_r;
  logic [CNT_W-1:0] needed;
  logic             state_chg;
  logic             os_valid;
  logic             qualify;
  logic             link_not_pad;
  logic             lane_not_pad;
  logic             link_match;

  assign state_chg    = (state_i != state_r);
  assign link_not_pad = (link_num_i != SYM_PAD);
  assign lane_not_pad = (lane_num_i != SYM_PAD);
  assign link_match   = (link_num_i == link_sel_i);

  // ------------------------------
  // counted kind and rule per state
  // ------------------------------
  always_comb begin
    needed   = '0;
    os_valid = 1'b0;
    qualify  = 1'b0;
    case (state_i)
      CFG_LW_START: begin
        needed   = CNT_W'(TS1_NEEDED);
        os_valid = ts1_valid_i;
        qualify  = link_not_pad && !lane_not_pad;
      end
      CFG_LW_ACCEPT: begin
        needed   = CNT_W'(TS1_NEEDED);
        os_valid = ts1_valid_i;
        qualify  = link_match;
      end
      CFG_LN_WAIT: begin
        needed   = CNT_W'(TS1_NEEDED);
        os_valid = ts1_valid_i;
        qualify  = link_not_pad && lane_not_pad;
      end
      CFG_LN_ACCEPT: begin
        needed   = CNT_W'(TS1_NEEDED);
        os_valid = ts1_valid_i;
        qualify  = link_match && lane_not_pad;
      end
      CFG_COMPLETE: begin
        needed   = CNT_W'(TS2_NEEDED);
        os_valid = ts2_valid_i;
        qualify  = link_match && (lane_num_i == lane_tx_i);
      end
      CFG_IDLE_OS: begin
        needed   = CNT_W'(IDLE_NEEDED);
        os_valid = idle_valid_i;
        qualify  = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // ------------------------------
  // counter
  // ------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r <= CFG_IDLE;
      cnt_r   <= '0;
    end else begin
      state_r <= state_i;
      if (state_chg) begin
        cnt_r <= '0;
      end else if (os_valid && (cnt_r < needed)) begin
        // a broken run starts over
        cnt_r <= qualify ? cnt_r + 1'b1 : '0;
      end
    end
  end

  // old count is stale in the first cycle of a new state
  assign done_o      = (needed != '0) && (cnt_r >= needed) && !state_chg;
  assign idle_seen_o = (state_i == CFG_IDLE_OS) && (cnt_r != '0) && !state_chg;

endmodule

//--- lane_tracker.sv
// lane counters, link number selection and state exit condition
`timescale 1ns/100ps

module lane_tracker
  import pcie_os_pkg::*;
  import ltssm_cfg_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  cfg_state_e             state_i,
  input  logic [NUM_LANES-1:0]   ts1_valid_i,
  input  logic [NUM_LANES-1:0]   ts2_valid_i,
  input  logic [NUM_LANES-1:0]   idle_valid_i,
  input  logic [NUM_LANES*8-1:0] link_num_i,
  input  logic [NUM_LANES*8-1:0] lane_num_i,
  input  logic [NUM_LANES*8-1:0] lane_num_transmitted_i,
  input  logic [NUM_LANES-1:0]   lane_active_i,
  output logic                   exit_ok_o,
  output logic                   idle_seen_o,
  output os_sym_t                link_sel_o
);

  logic [NUM_LANES-1:0] done;
  logic [NUM_LANES-1:0] idle_seen;
  os_sym_t              link_first;
  os_sym_t              link_sel_r;
  logic                 select;

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    os_lane_counter u_cnt (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .state_i      (state_i),
      .ts1_valid_i  (ts1_valid_i[i]),
      .ts2_valid_i  (ts2_valid_i[i]),
      .idle_valid_i (idle_valid_i[i]),
      .link_num_i   (link_num_i[i*8 +: 8]),
      .lane_num_i   (lane_num_i[i*8 +: 8]),
      .lane_tx_i    (lane_num_transmitted_i[i*8 +: 8]),
      .link_sel_i   (link_sel_o),
      .done_o       (done[i]),
      .idle_seen_o  (idle_seen[i])
    );
  end

  // ------------------------------
  // link number of lowest done lane
  // ------------------------------
  always_comb begin
    link_first = link_sel_r;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (done[i]) begin
        link_first = link_num_i[i*8 +: 8];
      end
    end
  end

  assign select = (state_i == CFG_LW_START) && (|done);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      link_sel_r <= SYM_PAD;
    end else if (select) begin
      link_sel_r <= link_first;
    end
  end

  // bypass so the FSM sees the new link in the exit cycle
  assign link_sel_o = select ? link_first : link_sel_r;

  always_comb begin
    case (state_i)
      CFG_LW_START, CFG_LW_ACCEPT, CFG_LN_WAIT, CFG_LN_ACCEPT: exit_ok_o = |done;
      // inactive lanes count as complete
      CFG_COMPLETE, CFG_IDLE_OS: exit_ok_o = &(done | ~lane_active_i);
      default: exit_ok_o = 1'b0;
    endcase
  end

  assign idle_seen_o = |idle_seen;

endmodule

//--- os_frame_tx.sv
// ordered-set frame transmitter on a valid/ready stream
`timescale 1ns/100ps

module os_frame_tx #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  tx_en_i,
  input  logic [127:0]          os_i,
  input  logic [7:0]            tuser_i,
  input  logic                  m_axis_tready_i,
  output logic [DATA_WIDTH-1:0] m_axis_tdata_o,
  output logic                  m_axis_tvalid_o,
  output logic                  m_axis_tlast_o,
  output logic [7:0]            m_axis_tuser_o,
  output logic                  frame_start_o
);

  localparam int OS_BITS = 128;
  localparam int BEATS = OS_BITS / DATA_WIDTH;
  localparam int BEAT_W = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BEATS - 1);

  logic [OS_BITS-1:0]    frame_r;
  logic [BEAT_W-1:0]     beat_r;
  logic [DATA_WIDTH-1:0] tdata_r;
  logic                  tvalid_r;
  logic                  tlast_r;
  logic [7:0]            tuser_r;
  logic                  slot_free;
  logic                  load;

  // output register empty or being taken this cycle
  assign slot_free = !tvalid_r || m_axis_tready_i;
  assign load = tx_en_i && slot_free && (beat_r == '0);
  assign frame_start_o = load;

  // ------------------------------
  // beat sequencing
  // ------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tvalid_r <= 1'b0;
      beat_r   <= '0;
    end else if (slot_free) begin
      if (beat_r != '0) begin
        // a started frame always runs to its end
        tvalid_r <= 1'b1;
        beat_r   <= (beat_r == LAST_BEAT) ? '0 : beat_r + 1'b1;
      end else if (tx_en_i) begin
        tvalid_r <= 1'b1;
        beat_r   <= (BEATS > 1) ? BEAT_W'(1) : '0;
      end else begin
        tvalid_r <= 1'b0;
      end
    end
  end

  // ------------------------------
  // frame and beat payload
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (load) begin
      frame_r <= os_i;
      tdata_r <= os_i[DATA_WIDTH-1:0];
      tlast_r <= (BEATS == 1);
      tuser_r <= tuser_i;
    end else if (slot_free && (beat_r != '0)) begin
      tdata_r <= frame_r[beat_r*DATA_WIDTH +: DATA_WIDTH];
      tlast_r <= (beat_r == LAST_BEAT);
    end
  end

  assign m_axis_tdata_o  = tdata_r;
  assign m_axis_tvalid_o = tvalid_r;
  assign m_axis_tlast_o  = tlast_r;
  assign m_axis_tuser_o  = tuser_r;

endmodule

//--- config_fsm.sv
// configuration substate FSM with timeout timer, idle-sent counter
// and success/error flags
`timescale 1ns/100ps

module config_fsm
  import pcie_os_pkg::*;
  import ltssm_cfg_pkg::*;
#(
  parameter int TIMEOUT_START = 24000,
  parameter int TIMEOUT_STEP  = 2000
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         en_i,
  input  logic         recovery_i,
  input  logic         is_timeout_i,
  input  logic         frame_start_i,
  input  logic         exit_ok_i,
  input  logic         idle_seen_i,
  input  os_sym_t      link_sel_i,
  output cfg_state_e   state_o,
  output ordered_set_t os_o,
  output logic         tx_en_o,
  output logic [7:0]   tuser_o,
  output logic         success_o,
  output logic         error_o
);

  localparam int TMAX = (TIMEOUT_START > TIMEOUT_STEP) ? TIMEOUT_START : TIMEOUT_STEP;
  localparam int TMR_W = $clog2(TMAX + 1);
  localparam int SENT_W = $clog2(IDLE_SENT_NEEDED + 1);
  localparam logic [SENT_W-1:0] SENT_MAX = SENT_W'(IDLE_SENT_NEEDED);

  cfg_state_e        state_r, state_c;
  ordered_set_t      os_r, os_c;
  logic [TMR_W-1:0]  timer_r, timer_c;
  logic [TMR_W-1:0]  limit;
  logic [SENT_W-1:0] sent_r, sent_c;
  logic              success_r, success_c;
  logic              error_r, error_c;
  logic              sending;
  logic              timed_out;
  logic              leave;

  assign sending = state_r inside {CFG_LW_START, CFG_LW_ACCEPT, CFG_LN_WAIT,
                                   CFG_LN_ACCEPT, CFG_COMPLETE, CFG_IDLE_OS};
  // Linkwidth.Start gets the long limit
  assign limit = (state_r == CFG_LW_START) ? TMR_W'(TIMEOUT_START) : TMR_W'(TIMEOUT_STEP);
  assign timed_out = (timer_r >= limit);
  // idle state also needs enough idle frames sent
  assign leave = exit_ok_i && ((state_r != CFG_IDLE_OS) || (sent_r >= SENT_MAX));

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    state_c   = state_r;
    os_c      = os_r;
    timer_c   = timer_r;
    sent_c    = sent_r;
    success_c = success_r;
    error_c   = error_r;
    // bounded timer
    if (sending) begin
      timer_c = timed_out ? limit : timer_r + 1'b1;
    end
    if (state_r == CFG_IDLE) begin
      if (en_i) begin
        state_c = CFG_LW_START;
        os_c    = build_ts1(SYM_PAD, recovery_i && !is_timeout_i);
        timer_c = '0;
        sent_c  = '0;
      end
    end else if (state_r == CFG_WAIT_EN_LOW) begin
      if (!en_i) begin
        state_c   = CFG_IDLE;
        success_c = 1'b0;
        error_c   = 1'b0;
      end
    end else if (sending && frame_start_i) begin
      // exits only at frame boundaries
      if ((state_r == CFG_IDLE_OS) && idle_seen_i && (sent_r < SENT_MAX)) begin
        sent_c = sent_r + 1'b1;
      end
      if (leave) begin
        timer_c = '0;
        case (state_r)
          CFG_LW_START: begin
            state_c = CFG_LW_ACCEPT;
            os_c    = build_ts1(link_sel_i, 1'b0);
          end
          CFG_LW_ACCEPT: state_c = CFG_LN_WAIT;
          CFG_LN_WAIT:   state_c = CFG_LN_ACCEPT;
          CFG_LN_ACCEPT: begin
            state_c = CFG_COMPLETE;
            os_c    = build_ts2(link_sel_i);
          end
          CFG_COMPLETE: begin
            state_c = CFG_IDLE_OS;
            os_c    = build_idle();
            sent_c  = '0;
          end
          default: begin
            state_c   = CFG_WAIT_EN_LOW;
            success_c = 1'b1;
          end
        endcase
      end else if (timed_out) begin
        state_c = CFG_WAIT_EN_LOW;
        error_c = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r   <= CFG_IDLE;
      timer_r   <= '0;
      sent_r    <= '0;
      success_r <= 1'b0;
      error_r   <= 1'b0;
    end else begin
      state_r   <= state_c;
      timer_r   <= timer_c;
      sent_r    <= sent_c;
      success_r <= success_c;
      error_r   <= error_c;
    end
  end

  always_ff @(posedge clk_i) begin
    os_r <= os_c;
  end

  assign state_o   = state_r;
  assign os_o      = os_r;
  assign tx_en_o   = sending;
  assign tuser_o   = (state_r == CFG_LW_START) ? 8'h01 : 8'h03;
  assign success_o = success_r;
  assign error_o   = error_r;

endmodule

//--- ltssm_config.sv
// downstream-port configuration substates, FSM, lane tracking and frame transmitter
`timescale 1ns/100ps

module ltssm_config
  import pcie_os_pkg::*;
  import ltssm_cfg_pkg::*;
#(
  parameter int NUM_LANES     = 4,
  parameter int DATA_WIDTH    = 32,
  parameter int TIMEOUT_START = 24000,
  parameter int TIMEOUT_STEP  = 2000
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // parent LTSSM
  input  logic                   en_i,
  input  logic                   recovery_i,
  input  logic                   is_timeout_i,
  output logic                   success_o,
  output logic                   error_o,
  // receive side, per lane
  input  logic [NUM_LANES-1:0]   ts1_valid_i,
  input  logic [NUM_LANES-1:0]   ts2_valid_i,
  input  logic [NUM_LANES-1:0]   idle_valid_i,
  input  logic [NUM_LANES*8-1:0] link_num_i,
  input  logic [NUM_LANES*8-1:0] lane_num_i,
  input  logic [NUM_LANES*8-1:0] lane_num_transmitted_i,
  input  logic [NUM_LANES-1:0]   lane_active_i,
  // transmit stream
  output logic [DATA_WIDTH-1:0]  m_axis_tdata_o,
  output logic                   m_axis_tvalid_o,
  output logic                   m_axis_tlast_o,
  output logic [7:0]             m_axis_tuser_o,
  input  logic                   m_axis_tready_i
);

  cfg_state_e   state;
  ordered_set_t os;
  os_sym_t      link_sel;
  logic         tx_en;
  logic [7:0]   tuser;
  logic         frame_start;
  logic         exit_ok;
  logic         idle_seen;

  config_fsm #(
    .TIMEOUT_START (TIMEOUT_START),
    .TIMEOUT_STEP  (TIMEOUT_STEP)
  ) u_fsm (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .en_i          (en_i),
    .recovery_i    (recovery_i),
    .is_timeout_i  (is_timeout_i),
    .frame_start_i (frame_start),
    .exit_ok_i     (exit_ok),
    .idle_seen_i   (idle_seen),
    .link_sel_i    (link_sel),
    .state_o       (state),
    .os_o          (os),
    .tx_en_o       (tx_en),
    .tuser_o       (tuser),
    .success_o     (success_o),
    .error_o       (error_o)
  );

  lane_tracker #(
    .NUM_LANES (NUM_LANES)
  ) u_lanes (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .state_i                (state),
    .ts1_valid_i            (ts1_valid_i),
    .ts2_valid_i            (ts2_valid_i),
    .idle_valid_i           (idle_valid_i),
    .link_num_i             (link_num_i),
    .lane_num_i             (lane_num_i),
    .lane_num_transmitted_i (lane_num_transmitted_i),
    .lane_active_i          (lane_active_i),
    .exit_ok_o              (exit_ok),
    .idle_seen_o            (idle_seen),
    .link_sel_o             (link_sel)
  );

  os_frame_tx #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_tx (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .tx_en_i         (tx_en),
    .os_i            (os),
    .tuser_i         (tuser),
    .m_axis_tready_i (m_axis_tready_i),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tuser_o  (m_axis_tuser_o),
    .frame_start_o   (frame_start)
  );

endmodule

//--- tb_ltssm_config.sv
// testbench for the configuration substates
// clock, reset, receive-side stimulus, stream monitor and directed tests
`timescale 1ns/100ps

module tb_ltssm_config;
  import pcie_os_pkg::*;
  import ltssm_cfg_pkg::*;

  // all five tests together take about 1100 cycles
  localparam int MAX_CYCLES = 20000;

  logic        clk_i = 1'b0;
  logic        rst_i = 1'b1;
  logic        en_i = 1'b0;
  logic        recovery_i = 1'b0;
  logic        is_timeout_i = 1'b0;
  logic [3:0]  ts1_valid_i = '0;
  logic [3:0]  ts2_valid_i = '0;
  logic [3:0]  idle_valid_i = '0;
  logic [31:0] link_num_i = {4{SYM_PAD}};
  logic [31:0] lane_num_i = {4{SYM_PAD}};
  logic [31:0] lane_num_transmitted_i = {8'd3, 8'd2, 8'd1, 8'd0};
  logic [3:0]  lane_active_i = 4'b0110;
  logic        m_axis_tready_i = 1'b1;
  logic [31:0] m_axis_tdata_o;
  logic        m_axis_tvalid_o;
  logic        m_axis_tlast_o;
  logic [7:0]  m_axis_tuser_o;
  logic        success_o;
  logic        error_o;

  ordered_set_t frames[$];
  logic [7:0]   frame_users[$];
  ordered_set_t acc;
  logic [7:0]   first_user;
  logic [31:0]  hold_data;
  logic         hold_last;
  logic [7:0]   hold_user;
  logic         stalled = 1'b0;
  int           beat = 0;
  int           cycles = 0;
  logic         rand_ready = 1'b0;

  ltssm_config #(
    .NUM_LANES     (4),
    .DATA_WIDTH    (32),
    .TIMEOUT_START (400),
    .TIMEOUT_STEP  (200)
  ) dut0 (.*);

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  task automatic report_fail(string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "run stopped on error");
  endtask

  // ------------------------------
  // watchdog and ready driver
  // ------------------------------
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $fatal(1, "watchdog expired");
    end
  end

  initial begin
    void'($urandom(32'h38b8));
    forever begin
      @(posedge clk_i);
      #10;
      if (rand_ready) begin
        m_axis_tready_i = ($urandom % 4) != 0;
      end
    end
  end

  // ------------------------------
  // stream monitor
  // ------------------------------
  always @(posedge clk_i) begin
    if (rst_i) begin
      beat = 0;
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        assert (m_axis_tvalid_o && m_axis_tdata_o == hold_data &&
                m_axis_tlast_o == hold_last && m_axis_tuser_o == hold_user)
        else report_fail("stream beat changed while stalled");
      end
      if (m_axis_tvalid_o && m_axis_tready_i) begin
        assert (m_axis_tlast_o == (beat == 3))
        else report_fail($sformatf("tlast wrong on beat %0d", beat));
        if (beat == 0) begin
          first_user = m_axis_tuser_o;
        end
        assert (m_axis_tuser_o == first_user)
        else report_fail("tuser changed inside a frame");
        // four symbols per beat
        acc[beat*4 +: 4] = m_axis_tdata_o;
        if (beat == 3) begin
          frames.push_back(acc);
          frame_users.push_back(first_user);
          beat = 0;
        end else begin
          beat++;
        end
      end
      stalled   = m_axis_tvalid_o && !m_axis_tready_i;
      hold_data = m_axis_tdata_o;
      hold_last = m_axis_tlast_o;
      hold_user = m_axis_tuser_o;
    end
  end

  // expected training set built from the symbol layout
  function automatic ordered_set_t make_ts(os_sym_t id, os_sym_t link, logic rate);
    ordered_set_t s;
    s = '0;
    s[0] = SYM_COM;
    s[1] = link;
    s[2] = SYM_PAD;
    s[4] = rate ? 8'h42 : 8'h02;
    for (int i = 6; i < 16; i++) begin
      s[i] = id;
    end
    return s;
  endfunction

  task automatic apply_reset();
    @(posedge clk_i);
    #10;
    rst_i = 1'b1;
    en_i = 1'b0;
    rand_ready = 1'b0;
    m_axis_tready_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #10;
    rst_i = 1'b0;
    frames.delete();
    frame_users.delete();
  endtask

  // one received set on each lane in mask
  // kind selects TS1 (0), TS2 (1) or idle (2)
  task automatic send_set(int kind, logic [3:0] mask, logic [31:0] link, logic [31:0] lane);
    @(posedge clk_i);
    #10;
    link_num_i = link;
    lane_num_i = lane;
    ts1_valid_i = (kind == 0) ? mask : 4'b0;
    ts2_valid_i = (kind == 1) ? mask : 4'b0;
    idle_valid_i = (kind == 2) ? mask : 4'b0;
    @(posedge clk_i);
    #10;
    ts1_valid_i = '0;
    ts2_valid_i = '0;
    idle_valid_i = '0;
  endtask

  // keep sending until the next set appears
  // frames before it must all be the current set
  task automatic train_phase(int kind, logic [31:0] link, logic [31:0] lane,
                             ordered_set_t cur, logic [7:0] cur_user,
                             ordered_set_t nxt, logic [7:0] nxt_user);
    ordered_set_t f;
    logic [7:0]   u;
    logic         seen;
    seen = 1'b0;
    while (!seen) begin
      send_set(kind, 4'b0110, link, lane);
      while (frames.size() > 0 && !seen) begin
        f = frames.pop_front();
        u = frame_users.pop_front();
        if (f == nxt) begin
          seen = 1'b1;
          assert (u == nxt_user) else report_fail("tuser wrong on new set");
        end else begin
          assert (f == cur && u == cur_user)
          else report_fail($sformatf("unexpected frame %h user %h", f, u));
        end
      end
    end
  endtask

  task automatic full_training();
    ordered_set_t idle_os;
    int           idle_frames;
    idle_os = '0;
    idle_frames = 0;
    train_phase(0, {SYM_PAD, 8'd5, 8'd9, SYM_PAD}, {4{SYM_PAD}},
                make_ts(SYM_TS1_ID, SYM_PAD, 1'b0), 8'h01,
                make_ts(SYM_TS1_ID, 8'd9, 1'b0), 8'h03);
    train_phase(0, {SYM_PAD, 8'd9, 8'd9, SYM_PAD}, {SYM_PAD, 8'd2, 8'd1, SYM_PAD},
                make_ts(SYM_TS1_ID, 8'd9, 1'b0), 8'h03,
                make_ts(SYM_TS2_ID, 8'd9, 1'b0), 8'h03);
    train_phase(1, {SYM_PAD, 8'd9, 8'd9, SYM_PAD}, lane_num_transmitted_i,
                make_ts(SYM_TS2_ID, 8'd9, 1'b0), 8'h03, idle_os, 8'h03);
    idle_frames = 1;
    while (!success_o) begin
      assert (!error_o) else report_fail("error raised during idle exchange");
      send_set(2, 4'b0110, {4{SYM_PAD}}, {4{SYM_PAD}});
      while (frames.size() > 0) begin
        assert (frames.pop_front() == idle_os) else report_fail("non-idle frame");
        void'(frame_users.pop_front());
        idle_frames++;
      end
    end
    assert (idle_frames >= 16)
    else report_fail($sformatf("success after only %0d idle frames", idle_frames));
    assert (!error_o) else report_fail("error set together with success");
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic first_ts1_frames();
    int wait_cycles;
    apply_reset();
    assert (!m_axis_tvalid_o && !success_o && !error_o)
    else report_fail("outputs not idle after reset");
    recovery_i = 1'b1;
    en_i = 1'b1;
    wait_cycles = 0;
    while (!m_axis_tvalid_o) begin
      @(posedge clk_i);
      #10;
      wait_cycles++;
      assert (wait_cycles <= 3) else report_fail("first beat later than 3 cycles");
    end
    while (frames.size() < 3) @(posedge clk_i);
    for (int i = 0; i < 3; i++) begin
      assert (frames[i] == make_ts(SYM_TS1_ID, SYM_PAD, 1'b1) && frame_users[i] == 8'h01)
      else report_fail($sformatf("first TS1 frame %0d is %h", i, frames[i]));
    end
    recovery_i = 1'b0;
  endtask

  task automatic link_training();
    apply_reset();
    en_i = 1'b1;
    full_training();
  endtask

  task automatic stalled_training();
    apply_reset();
    en_i = 1'b1;
    m_axis_tready_i = 1'b0;
    repeat (20) @(posedge clk_i);
    rand_ready = 1'b1;
    full_training();
  endtask

  task automatic training_timeout();
    apply_reset();
    en_i = 1'b1;
    while (!error_o) begin
      @(posedge clk_i);
      assert (!success_o) else report_fail("success without any TS1");
    end
    #10;
    en_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    assert (!success_o && !error_o) else report_fail("flags not cleared after en low");
    repeat (4) @(posedge clk_i);
    #10;
    assert (!m_axis_tvalid_o) else report_fail("stream still valid after error");
  endtask

  task automatic broken_ts1_run();
    logic [31:0] good_link;
    good_link = {SYM_PAD, SYM_PAD, 8'd9, SYM_PAD};
    apply_reset();
    en_i = 1'b1;
    // counters clear in the first cycle of LW_START
    while (!m_axis_tvalid_o) @(posedge clk_i);
    send_set(0, 4'b0010, good_link, {4{SYM_PAD}});
    send_set(0, 4'b0010, good_link, {SYM_PAD, SYM_PAD, 8'd1, SYM_PAD});
    send_set(0, 4'b0010, good_link, {4{SYM_PAD}});
    repeat (16) @(posedge clk_i);
    #10;
    while (frames.size() > 0) begin
      assert (frames.pop_front() == make_ts(SYM_TS1_ID, SYM_PAD, 1'b0))
      else report_fail("link chosen after a broken run");
      void'(frame_users.pop_front());
    end
    send_set(0, 4'b0010, good_link, {4{SYM_PAD}});
    train_phase(0, good_link, {4{SYM_PAD}},
                make_ts(SYM_TS1_ID, SYM_PAD, 1'b0), 8'h01,
                make_ts(SYM_TS1_ID, 8'd9, 1'b0), 8'h03);
  endtask

  initial begin
    first_ts1_frames();
    link_training();
    stalled_training();
    training_timeout();
    broken_ts1_run();
    $display("sim passed");
    $finish;
  end

endmodule

//--- sim.f
pcie_os_pkg.sv
ltssm_cfg_pkg.sv
os_lane_counter.sv
lane_tracker.sv
os_frame_tx.sv
config_fsm.sv
ltssm_config.sv
tb_ltssm_config.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wall -f sim.f --top-module tb_ltssm_config -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "sim passed" sim.log; then
  exit 0
fi
exit 1
